/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
LINT      := --lint-only --timing --assert
TOP       := tbConvEngine
FILELIST  := sources.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/convControl.sv */
`timescale 1ns/1ps

module convControl import convPkg::*; #(
    parameter int LaneCount = 3
) (
    input  logic   Clk,
    input  logic   Rst,
    input  logic   start,
    input  logic   holdCoeffs,
    input  sampleT popData,
    input  logic   empty,
    output logic   pop,
    laneIf.ctrl    lanes,
    output logic   finalAdd,
    output logic   clear,
    input  logic   resultValid
);

    localparam int PtrW  = (LaneCount > 1) ? $clog2(LaneCount) : 1;
    localparam int PairW = $clog2(KernelTaps + 1);

    ctrlStateT        state;
    logic             inputToggle;  // High while the next word is a coefficient
    logic             holdLatched;
    logic             drainCount;
    logic [PtrW-1:0]  lanePtr;
    logic [PairW-1:0] pairCount;

    // Words are taken straight off the FIFO head whenever one is there
    assign pop = (state == Read) && !empty;

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state          <= Idle;
            inputToggle    <= 1'b0;
            holdLatched    <= 1'b0;
            drainCount     <= 1'b0;
            lanePtr        <= '0;
            pairCount      <= '0;
            clear          <= 1'b0;
            finalAdd       <= 1'b0;
            lanes.mulStart <= '0;
            for (int i = 0; i < LaneCount; i++) begin
                lanes.coeff[i] <= '0;
            end
        end else begin
            // Single-cycle strobes
            lanes.mulStart <= '0;
            clear          <= 1'b0;
            finalAdd       <= 1'b0;

            case (state)
                Idle: begin
                    if (start) begin
                        state       <= Read;
                        holdLatched <= holdCoeffs;
                        clear       <= 1'b1;
                        inputToggle <= 1'b0;
                        lanePtr     <= '0;
                        pairCount   <= '0;
                    end
                end

                Read: begin
                    if (pop) begin
                        inputToggle <= !inputToggle;
                        if (inputToggle) begin
                            // Coefficient word is popped even when the bank is held
                            if (!holdLatched) begin
                                lanes.coeff[lanePtr] <= popData;
                            end
                            lanes.mulStart[lanePtr] <= 1'b1;
                            lanePtr   <= (lanePtr == PtrW'(LaneCount - 1)) ? '0
                                                                           : lanePtr + 1'b1;
                            pairCount <= pairCount + 1'b1;
                            if (pairCount == PairW'(KernelTaps - 1)) begin
                                state      <= Drain;
                                drainCount <= 1'b0;
                            end
                        end
                    end
                end

                // Wait for the last product to reach the accumulator
                Drain: begin
                    drainCount <= 1'b1;
                    if (drainCount) begin
                        state    <= Add;
                        finalAdd <= 1'b1;
                    end
                end

                // Result is held downstream until acknowledged
                Add: begin
                    if (!finalAdd && !resultValid) begin
                        state <= Idle;
                    end
                end

                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (pop && !inputToggle) begin
            lanes.pixel[lanePtr] <= popData;
        end
    end

endmodule

/* hdl/convEngine.sv */
`timescale 1ns/1ps

module convEngine import convPkg::*; #(
    parameter int LaneCount = 3,
    parameter int FifoDepth = 8
) (
    input  logic   Clk,
    input  logic   Rst,
    input  sampleT inData,
    input  logic   inValid,
    output logic   inReady,
    input  logic   start,
    input  logic   holdCoeffs,
    output resultT result,
    output logic   resultValid,
    input  logic   resultAck
);

    logic   full;
    logic   empty;
    logic   pop;
    sampleT popData;
    logic   finalAdd;
    logic   clear;

    laneIf #(.LaneCount(LaneCount)) lanes ();

    assign inReady = !full;

    // Input side
    sampleFifo #(.FifoDepth(FifoDepth)) uFifo (
        .Clk      (Clk),
        .Rst      (Rst),
        .pushData (inData),
        .push     (inValid),
        .full     (full),
        .popData  (popData),
        .pop      (pop),
        .empty    (empty)
    );

    convControl #(.LaneCount(LaneCount)) uControl (
        .Clk         (Clk),
        .Rst         (Rst),
        .start       (start),
        .holdCoeffs  (holdCoeffs),
        .popData     (popData),
        .empty       (empty),
        .pop         (pop),
        .lanes       (lanes.ctrl),
        .finalAdd    (finalAdd),
        .clear       (clear),
        .resultValid (resultValid)
    );

    laneMultipliers #(.LaneCount(LaneCount)) uMult (
        .Clk   (Clk),
        .Rst   (Rst),
        .lanes (lanes.mult)
    );

    // Output side
    productSum #(.LaneCount(LaneCount)) uSum (
        .Clk         (Clk),
        .Rst         (Rst),
        .lanes       (lanes.sum),
        .clear       (clear),
        .finalAdd    (finalAdd),
        .result      (result),
        .resultValid (resultValid),
        .resultAck   (resultAck)
    );

endmodule

/* hdl/convPkg.sv */
package convPkg;

    // Stream word, carries either a pixel or a coefficient
    typedef logic [7:0] sampleT;

    // Product of one pixel and one coefficient
    typedef logic [15:0] productT;

    // Nine full-scale products fit in 20 bits
    typedef logic [19:0] resultT;

    // Pixel/coefficient pairs in one 3x3 window
    localparam int KernelTaps = 9;

    // Window controller states
    typedef enum logic [1:0] {
        Idle,
        Read,
        Drain,
        Add
    } ctrlStateT;

endpackage

/* hdl/laneIf.sv */
`timescale 1ns/1ps

interface laneIf import convPkg::*; #(
    parameter int LaneCount = 3
) ();

    // Operands loaded by the controller, one pair per lane
    sampleT                 pixel [LaneCount];
    sampleT                 coeff [LaneCount];
    logic [LaneCount-1:0]   mulStart;

    // Registered lane results
    productT                product [LaneCount];
    logic [LaneCount-1:0]   productValid;

    modport ctrl (output pixel, output coeff, output mulStart);

    modport mult (
        input  pixel, input coeff, input mulStart,
        output product, output productValid
    );

    modport sum (input product, input productValid);

endinterface

/* hdl/laneMultipliers.sv */
`timescale 1ns/1ps

module laneMultipliers import convPkg::*; #(
    parameter int LaneCount = 3
) (
    input  logic Clk,
    input  logic Rst,
    laneIf.mult  lanes
);

    // Valid follows the start strobe by one cycle
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            lanes.productValid <= '0;
        end else begin
            lanes.productValid <= lanes.mulStart;
        end
    end

    // One unsigned 8x8 multiplier per lane
    always_ff @(posedge Clk) begin
        for (int i = 0; i < LaneCount; i++) begin
            if (lanes.mulStart[i]) begin
                lanes.product[i] <= productT'(lanes.pixel[i]) * productT'(lanes.coeff[i]);
            end
        end
    end

endmodule

/* hdl/productSum.sv */
`timescale 1ns/1ps

module productSum import convPkg::*; #(
    parameter int LaneCount = 3
) (
    input  logic   Clk,
    input  logic   Rst,
    laneIf.sum     lanes,
    input  logic   clear,
    input  logic   finalAdd,
    output resultT result,
    output logic   resultValid,
    input  logic   resultAck
);

    resultT acc;
    resultT laneSum;

    // Sum of the products that land this cycle
    always_comb begin
        laneSum = '0;
        for (int i = 0; i < LaneCount; i++) begin
            if (lanes.productValid[i]) begin
                laneSum = laneSum + resultT'(lanes.product[i]);
            end
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            acc         <= '0;
            resultValid <= 1'b0;
        end else begin
            acc <= clear ? '0 : acc + laneSum;
            if (finalAdd) begin
                resultValid <= 1'b1;
            end else if (resultValid && resultAck) begin
                resultValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (finalAdd) begin
            result <= acc;
        end
    end

endmodule

/* hdl/sampleFifo.sv */
`timescale 1ns/1ps

module sampleFifo import convPkg::*; #(
    parameter int FifoDepth = 8
) (
    input  logic   Clk,
    input  logic   Rst,
    input  sampleT pushData,
    input  logic   push,
    output logic   full,
    output sampleT popData,
    input  logic   pop,
    output logic   empty
);

    localparam int AddrW = $clog2(FifoDepth);

    sampleT           mem [FifoDepth];
    logic [AddrW-1:0] wrPtr;
    logic [AddrW-1:0] rdPtr;
    logic [AddrW:0]   count;
    logic             doPush;
    logic             doPop;

    // Requests that cannot be served are dropped
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign full  = (count == (AddrW + 1)'(FifoDepth));
    assign empty = (count == '0);

    // Head word is always presented on the pop side
    assign popData = mem[rdPtr];

    always_ff @(posedge Clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the occupancy unchanged
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* sim/convEngine_assertions.sv */
`timescale 1ns/1ps

module convEngine_assertions import convPkg::*; #(
    parameter int LaneCount = 3
) (
    input logic                 Clk,
    input logic                 Rst,
    input logic                 inValid,
    input logic                 inReady,
    input logic                 resultValid,
    input resultT               result,
    input logic                 resultAck,
    input logic                 finalAdd,
    input logic                 pop,
    input logic                 empty,
    input logic [LaneCount-1:0] mulStart
);

    int failCount = 0;
    int wordsHeld;

    // Occupancy rebuilt from the push and pop handshakes
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wordsHeld <= 0;
        end else begin
            wordsHeld <= wordsHeld + int'(inValid && inReady) - int'(pop);
        end
    end

    // Reset leaves the input side open and every strobe low
    assert property (@(posedge Clk)
        $fell(Rst) |-> inReady && !resultValid && !pop && !finalAdd && mulStart == '0)
        else begin
            failCount++;
            $error("Outputs not at their reset values when reset ends");
        end

    assert property (@(posedge Clk) disable iff (Rst) pop |-> wordsHeld > 0)
        else begin
            failCount++;
            $error("Pop issued while the FIFO is empty");
        end

    // No lane start is ever two cycles wide
    assert property (@(posedge Clk) disable iff (Rst) (mulStart & $past(mulStart)) == '0)
        else begin
            failCount++;
            $error("A lane start pulse lasted more than one cycle");
        end

    // One final add per window, only after the previous result was taken
    assert property (@(posedge Clk) disable iff (Rst)
        finalAdd |-> !resultValid ##1 (!finalAdd && resultValid))
        else begin
            failCount++;
            $error("Final add repeated or not followed by a valid result");
        end

    assert property (@(posedge Clk) disable iff (Rst) $rose(resultValid) |-> $past(finalAdd))
        else begin
            failCount++;
            $error("Result became valid without a final add one cycle before");
        end

    assert property (@(posedge Clk) disable iff (Rst)
        resultValid && !resultAck |=> resultValid && $stable(result))
        else begin
            failCount++;
            $error("Result changed or was dropped before it was acknowledged");
        end

endmodule

bind convEngine convEngine_assertions #(.LaneCount(LaneCount)) uChecks (
    .Clk         (Clk),
    .Rst         (Rst),
    .inValid     (inValid),
    .inReady     (inReady),
    .resultValid (resultValid),
    .result      (result),
    .resultAck   (resultAck),
    .finalAdd    (finalAdd),
    .pop         (pop),
    .empty       (empty),
    .mulStart    (lanes.mulStart)
);

/* sim/tbConvEngine.sv */
`timescale 1ns/1ps

module tbConvEngine import convPkg::*; ();

    localparam int LaneCount   = 3;
    localparam int NumWindows  = 8;
    localparam int StallWindow = 4;
    localparam int WaitLimit   = 400;

    logic   Clk;
    logic   Rst;
    sampleT inData;
    logic   inValid;
    logic   inReady;
    logic   start;
    logic   holdCoeffs;
    resultT result;
    logic   resultValid;
    logic   resultAck;

    logic [31:0] lfsrState;
    sampleT      stream [$];
    int          expected [$];
    bit          holdFlags [$];
    int          checkErrors;
    int          timeouts;

    convEngine u_dut (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic nextRandomBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'hA300_0000;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], nextRandomBit()};
        end
        return value;
    endfunction

    // Stream words and expected sums; lane i sees taps i, i+3 and i+6
    task automatic buildWindows();
        int     laneCoeff [LaneCount] = '{default: 0};
        int     sum;
        sampleT pixel;
        sampleT coeff;
        bit     hold;
        for (int w = 0; w < NumWindows; w++) begin
            hold = (w == 2 || w == 5);
            sum  = 0;
            for (int k = 0; k < KernelTaps; k++) begin
                pixel = sampleT'(randomBits(8));
                coeff = sampleT'(randomBits(8));
                stream.push_back(pixel);
                stream.push_back(coeff);
                // Held windows keep the lane coefficients of the last loaded window
                if (!hold) begin
                    laneCoeff[k % LaneCount] = int'(coeff);
                end
                sum += int'(pixel) * laneCoeff[k % LaneCount];
            end
            expected.push_back(sum);
            holdFlags.push_back(hold);
        end
    endtask

    task automatic waitResultValid(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (resultValid !== level && cycles < WaitLimit);
        if (resultValid !== level) begin
            timeouts++;
            $display("Timeout: resultValid did not go %s", level ? "high" : "low");
        end
    endtask

    task automatic waitInReady(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (inReady !== level && cycles < WaitLimit);
        if (inReady !== level) begin
            timeouts++;
            $display("Timeout: inReady did not go %s", level ? "high" : "low");
        end
    endtask

    // Word transfers on the rising edge after inReady is seen high
    task automatic pushStream();
        int gap;
        foreach (stream[i]) begin
            gap = int'(randomBits(2));
            repeat (gap) begin
                @(posedge Clk);
                inValid <= 1'b0;
            end
            @(posedge Clk);
            inData  <= stream[i];
            inValid <= 1'b1;
            waitInReady(1'b1);
        end
        @(posedge Clk);
        inValid <= 1'b0;
    endtask

    task automatic runWindows();
        for (int w = 0; w < NumWindows; w++) begin
            @(posedge Clk);
            start      <= 1'b1;
            holdCoeffs <= holdFlags[w];
            @(posedge Clk);
            start      <= 1'b0;
            holdCoeffs <= 1'b0;
            waitResultValid(1'b1);
            assert (result == resultT'(expected[w])) else begin
                checkErrors++;
                $display("Fail result in window %0d: got %h, expected %h",
                         w, result, resultT'(expected[w]));
            end
            // Hold the result until the next window backs up the FIFO
            if (w == StallWindow) begin
                waitInReady(1'b0);
            end
            @(posedge Clk);
            resultAck <= 1'b1;
            waitResultValid(1'b0);
            @(posedge Clk);
            resultAck <= 1'b0;
        end
    endtask

    initial begin
        Rst         <= 1'b1;
        inData      <= '0;
        inValid     <= 1'b0;
        start       <= 1'b0;
        holdCoeffs  <= 1'b0;
        resultAck   <= 1'b0;
        lfsrState   = 32'he0d9;
        checkErrors = 0;
        timeouts    = 0;
        buildWindows();
        repeat (10) @(posedge Clk);
        Rst <= 1'b0;
        @(negedge Clk);
        assert (inReady === 1'b1) else begin
            checkErrors++;
            $display("Fail inReady after reset: got %h, expected 1", inReady);
        end
        assert (resultValid === 1'b0) else begin
            checkErrors++;
            $display("Fail resultValid after reset: got %h, expected 0", resultValid);
        end
        fork
            pushStream();
            runWindows();
        join
        repeat (4) @(posedge Clk);
        $display("Errors: %0d checks, %0d timeouts, %0d assertions",
                 checkErrors, timeouts, u_dut.uChecks.failCount);
        if (checkErrors == 0 && timeouts == 0 && u_dut.uChecks.failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/convPkg.sv
hdl/laneIf.sv
hdl/sampleFifo.sv
hdl/convControl.sv
hdl/laneMultipliers.sv
hdl/productSum.sv
hdl/convEngine.sv
sim/convEngine_assertions.sv
sim/tbConvEngine.sv
